//--- verilog/firbank_macros.svh
// Polyphase interpolator sizing for tap and phase counts, datapath widths and Q15 scaling
`ifndef FIRBANK_MACROS_SVH
`define FIRBANK_MACROS_SVH

`define FIR_TAPS 32
`define FIR_PHASES 2

`define SAMPLE_W 16
`define COEF_W 16

// Holds 32 full-scale products with headroom
`define ACC_W 40

`define COEF_FRAC 15

`endif

//--- verilog/firbank_pkg.sv
// Polyphase interpolator types shared by the datapath and the testbench
`include "firbank_macros.svh"

package firbank_pkg;

        typedef logic signed [`SAMPLE_W-1:0] sample_t;

        typedef logic signed [`COEF_W-1:0] coef_t;

        typedef logic signed [`ACC_W-1:0] acc_t;

        // Tap age counted from 0 for the newest sample
        typedef logic [$clog2(`FIR_TAPS)-1:0] tap_t;

        typedef struct packed {
                sample_t sample;
                logic    phase;         // 0 for the first beat of a pair
        } out_beat_t;

        typedef enum logic [1:0] {
                IDLE,                   // Waiting for an input sample
                ACCUM,                  // One tap per clock
                HOLD                    // Result offered on the output
        } mac_state_t;

endpackage

//--- verilog/rom_firbank_half.sv
// Polyphase coefficient bank holding 32 Q15 taps for each of the two phases
`timescale 1ns/10ps

module rom_firbank_half (
        input  logic [5:0]          addr,
        output firbank_pkg::coef_t  data
);

        always_comb begin
                case (addr)                             // Phase 0 in the low half
                        6'd0:  data = -16'sd2;
                        6'd1:  data = -16'sd13;
                        6'd2:  data = 16'sd49;
                        6'd3:  data = -16'sd112;
                        6'd4:  data = 16'sd208;
                        6'd5:  data = -16'sd335;
                        6'd6:  data = 16'sd486;
                        6'd7:  data = -16'sd644;
                        6'd8:  data = 16'sd784;
                        6'd9:  data = -16'sd871;
                        6'd10: data = 16'sd855;
                        6'd11: data = -16'sd668;
                        6'd12: data = 16'sd190;
                        6'd13: data = 16'sd863;
                        6'd14: data = -16'sd3638;
                        6'd15: data = 16'sd27489;       // Main lobe
                        6'd16: data = 16'sd11503;
                        6'd17: data = -16'sd5489;
                        6'd18: data = 16'sd3533;
                        6'd19: data = -16'sd2399;
                        6'd20: data = 16'sd1600;
                        6'd21: data = -16'sd1003;
                        6'd22: data = 16'sd559;
                        6'd23: data = -16'sd243;
                        6'd24: data = 16'sd37;
                        6'd25: data = 16'sd81;
                        6'd26: data = -16'sd132;
                        6'd27: data = 16'sd137;
                        6'd28: data = -16'sd115;
                        6'd29: data = 16'sd82;
                        6'd30: data = -16'sd49;
                        6'd31: data = 16'sd23;
                        6'd32: data = 16'sd23;          // Phase 1 mirrors phase 0
                        6'd33: data = -16'sd49;
                        6'd34: data = 16'sd82;
                        6'd35: data = -16'sd115;
                        6'd36: data = 16'sd137;
                        6'd37: data = -16'sd132;
                        6'd38: data = 16'sd81;
                        6'd39: data = 16'sd37;
                        6'd40: data = -16'sd243;
                        6'd41: data = 16'sd559;
                        6'd42: data = -16'sd1003;
                        6'd43: data = 16'sd1600;
                        6'd44: data = -16'sd2399;
                        6'd45: data = 16'sd3533;
                        6'd46: data = -16'sd5489;
                        6'd47: data = 16'sd11503;
                        6'd48: data = 16'sd27489;
                        6'd49: data = -16'sd3638;
                        6'd50: data = 16'sd863;
                        6'd51: data = 16'sd190;
                        6'd52: data = -16'sd668;
                        6'd53: data = 16'sd855;
                        6'd54: data = -16'sd871;
                        6'd55: data = 16'sd784;
                        6'd56: data = -16'sd644;
                        6'd57: data = 16'sd486;
                        6'd58: data = -16'sd335;
                        6'd59: data = 16'sd208;
                        6'd60: data = -16'sd112;
                        6'd61: data = 16'sd49;
                        6'd62: data = -16'sd13;
                        6'd63: data = -16'sd2;
                endcase
        end

endmodule

//--- verilog/sample_history.sv
// Circular delay line that keeps the newest input samples for reads by tap age
`timescale 1ns/10ps
`include "firbank_macros.svh"

module sample_history (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    hist_wr,
        input  firbank_pkg::sample_t    wr_sample,
        input  firbank_pkg::tap_t       hist_tap,
        output firbank_pkg::sample_t    hist_sample
);

        import firbank_pkg::*;

        sample_t mem [`FIR_TAPS];
        tap_t    wr_ptr;                        // Slot for the next write
        tap_t    rd_ptr;

        // Newest sample sits just behind the write pointer
        assign rd_ptr = wr_ptr - hist_tap - tap_t'(1);

        assign hist_sample = mem[rd_ptr];

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        for (int i = 0; i < `FIR_TAPS; i++) begin
                                mem[i] <= '0;   // Outputs start from silence
                        end
                end else if (hist_wr) begin
                        mem[wr_ptr] <= wr_sample;
                        wr_ptr      <= wr_ptr + tap_t'(1);
                end
        end

endmodule

//--- verilog/polyphase_mac.sv
// Polyphase MAC engine with one tap per clock, Q15 rounding and saturation, and both handshakes
`timescale 1ns/10ps
`include "firbank_macros.svh"

module polyphase_mac (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    in_valid,
        output logic                    in_ready,
        output logic                    hist_wr,
        output firbank_pkg::tap_t       hist_tap,
        input  firbank_pkg::sample_t    hist_sample,
        output logic [5:0]              coef_addr,
        input  firbank_pkg::coef_t      coef_data,
        output logic                    out_valid,
        input  logic                    out_ready,
        output firbank_pkg::out_beat_t  out_beat
);

        import firbank_pkg::*;

        localparam acc_t sat_max   = acc_t'(2 ** (`SAMPLE_W - 1) - 1);
        localparam acc_t sat_min   = acc_t'(-(2 ** (`SAMPLE_W - 1)));
        localparam acc_t round_bit = acc_t'(1) <<< (`COEF_FRAC - 1);

        mac_state_t state;
        logic       phase;
        tap_t       tap;
        acc_t       acc;
        acc_t       rounded;
        sample_t    sat_sample;
        logic signed [`SAMPLE_W+`COEF_W-1:0] prod;

        assign in_ready  = (state == IDLE);
        assign hist_wr   = in_valid && in_ready;
        assign hist_tap  = tap;
        assign coef_addr = {phase, tap};

        assign prod    = hist_sample * coef_data;
        assign rounded = (acc + round_bit) >>> `COEF_FRAC;

        always_comb begin
                if (rounded > sat_max) begin
                        sat_sample = sample_t'(sat_max);
                end else if (rounded < sat_min) begin
                        sat_sample = sample_t'(sat_min);
                end else begin
                        sat_sample = rounded[`SAMPLE_W-1:0];
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        state     <= IDLE;
                        phase     <= 1'b0;
                        tap       <= '0;
                        out_valid <= 1'b0;
                end else begin
                        case (state)
                                IDLE: begin
                                        if (hist_wr) begin
                                                state <= ACCUM;
                                                phase <= 1'b0;
                                                tap   <= '0;
                                        end
                                end
                                ACCUM: begin
                                        tap <= tap + tap_t'(1);         // Wraps to 0 after the last tap
                                        if (tap == tap_t'(`FIR_TAPS - 1)) begin
                                                state <= HOLD;
                                        end
                                end
                                HOLD: begin
                                        if (!out_valid) begin
                                                out_valid <= 1'b1;      // Result is loaded this cycle
                                        end else if (out_ready) begin
                                                out_valid <= 1'b0;
                                                if (phase == 1'(`FIR_PHASES - 1)) begin
                                                        state <= IDLE;
                                                end else begin
                                                        phase <= phase + 1'b1;
                                                        state <= ACCUM;
                                                end
                                        end
                                end
                                default: state <= IDLE;
                        endcase
                end
        end

        // Accumulator restarts at zero for every phase
        always_ff @(posedge clk) begin
                if (state == ACCUM) begin
                        acc <= acc + acc_t'(prod);
                end else begin
                        acc <= '0;
                end
        end

        always_ff @(posedge clk) begin
                if (state == HOLD && !out_valid) begin
                        out_beat.sample <= sat_sample;
                        out_beat.phase  <= phase;
                end
        end

endmodule

//--- verilog/firbank_interp.sv
// Two-phase interpolating FIR top level joining the history, the coefficient bank and the engine
`timescale 1ns/10ps

module firbank_interp (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    in_valid,
        output logic                    in_ready,
        input  firbank_pkg::sample_t    in_sample,
        output logic                    out_valid,
        input  logic                    out_ready,
        output firbank_pkg::out_beat_t  out_beat
);

        import firbank_pkg::*;

        logic       hist_wr;
        tap_t       hist_tap;
        sample_t    hist_sample;
        logic [5:0] coef_addr;
        coef_t      coef_data;

        sample_history u_history (
                .clk            (clk),
                .rst_n          (rst_n),
                .hist_wr        (hist_wr),
                .wr_sample      (in_sample),
                .hist_tap       (hist_tap),
                .hist_sample    (hist_sample)
        );

        rom_firbank_half u_bank (
                .addr           (coef_addr),
                .data           (coef_data)
        );

        polyphase_mac u_mac (
                .clk            (clk),
                .rst_n          (rst_n),
                .in_valid       (in_valid),
                .in_ready       (in_ready),
                .hist_wr        (hist_wr),
                .hist_tap       (hist_tap),
                .hist_sample    (hist_sample),
                .coef_addr      (coef_addr),
                .coef_data      (coef_data),
                .out_valid      (out_valid),
                .out_ready      (out_ready),
                .out_beat       (out_beat)
        );

endmodule

//--- verif/firbank_properties.sv
// Handshake and reset assertions for the interpolator's input and output streams
`timescale 1ns/10ps

module firbank_properties (
        input logic                     clk,
        input logic                     rst_n,
        input logic                     in_ready,
        input logic                     out_valid,
        input logic                     out_ready,
        input firbank_pkg::out_beat_t   out_beat
);

        property beat_held;
                @(posedge clk) disable iff (!rst_n)
                        out_valid && !out_ready |=> out_valid && $stable(out_beat);
        endproperty

        property one_side_open;
                @(posedge clk) disable iff (!rst_n)
                        !(in_ready && out_valid);     // Engine takes input only while idle
        endproperty

        property reset_clears_valid;
                @(posedge clk) !rst_n |=> !out_valid;
        endproperty

        beat_held_a: assert property (beat_held)
                else $error("out_beat changed or out_valid dropped while stalled");
        one_side_open_a: assert property (one_side_open)
                else $error("in_ready and out_valid high together");
        reset_clears_valid_a: assert property (reset_clears_valid)
                else $error("out_valid high after reset");

endmodule

bind firbank_interp firbank_properties u_props (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_beat       (out_beat)
);

//--- verif/firbank_tb.sv
// Testbench for the two-phase interpolating FIR with a reference model and directed tests
`timescale 1ns/10ps
`include "firbank_macros.svh"

module firbank_tb;

        import firbank_pkg::*;

        localparam int wait_limit = 200;

        // Phase 0 half of the bank that phase 1 reads in reverse order
        localparam int coef_half [`FIR_TAPS] = '{
                -2, -13, 49, -112, 208, -335, 486, -644,
                784, -871, 855, -668, 190, 863, -3638, 27489,
                11503, -5489, 3533, -2399, 1600, -1003, 559, -243,
                37, 81, -132, 137, -115, 82, -49, 23
        };

        logic           clk = 1'b0;
        logic           rst_n;
        logic           in_valid;
        logic           in_ready;
        sample_t        in_sample;
        logic           out_valid;
        logic           out_ready;
        out_beat_t      out_beat;

        int             model_hist [`FIR_TAPS] = '{default: 0};     // Index 0 is the newest
        int             check_count = 0;
        int             err_count = 0;

        always #2 clk = ~clk;

        firbank_interp DUT (
                .clk            (clk),
                .rst_n          (rst_n),
                .in_valid       (in_valid),
                .in_ready       (in_ready),
                .in_sample      (in_sample),
                .out_valid      (out_valid),
                .out_ready      (out_ready),
                .out_beat       (out_beat)
        );

        function automatic void model_push(input sample_t s);
                int k;
                for (k = `FIR_TAPS - 1; k > 0; k--) begin
                        model_hist[k] = model_hist[k - 1];
                end
                model_hist[0] = int'(s);
        endfunction

        function automatic sample_t model_output(input int phase);
                longint acc;
                longint res;
                longint top;
                int     k;
                acc = 0;
                top = (longint'(1) <<< (`SAMPLE_W - 1)) - 1;
                for (k = 0; k < `FIR_TAPS; k++) begin
                        if (phase == 0) begin
                                acc += longint'(model_hist[k]) * longint'(coef_half[k]);
                        end else begin
                                acc += longint'(model_hist[k]) *
                                       longint'(coef_half[`FIR_TAPS - 1 - k]);
                        end
                end
                res = (acc + (longint'(1) <<< (`COEF_FRAC - 1))) >>> `COEF_FRAC;
                if (res > top) begin
                        res = top;
                end else if (res < -top - 1) begin
                        res = -top - 1;
                end
                return sample_t'(res);
        endfunction

        task automatic compare_sample(input string name, input sample_t got, input sample_t exp);
                check_count++;
                if (got !== exp) begin
                        err_count++;
                        $display("[FAIL] %s got %h expected %h", name, got, exp);
                end
        endtask

        task automatic compare_phase(input string name, input logic got, input logic exp);
                check_count++;
                if (got !== exp) begin
                        err_count++;
                        $display("[FAIL] %s got %h expected %h", name, got, exp);
                end
        endtask

        task automatic compare_flag(input string name, input logic got, input logic exp);
                check_count++;
                if (got !== exp) begin
                        err_count++;
                        $display("[FAIL] %s got %h expected %h", name, got, exp);
                end
        endtask

        task automatic stop_on_timeout(input string what);
                $display("Timed out waiting for %s to go high", what);
                $display("test failed");
                $finish;
        endtask

        task automatic apply_reset();
                int k;
                rst_n = 1'b0;
                for (k = 0; k < `FIR_TAPS; k++) begin
                        model_hist[k] = 0;
                end
                repeat (16) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
        endtask

        task automatic send_sample(input sample_t s);
                int cnt;
                cnt = 0;
                in_valid  = 1'b1;
                in_sample = s;
                while (!in_ready && cnt < wait_limit) begin
                        @(negedge clk);
                        cnt++;
                end
                if (!in_ready) begin
                        stop_on_timeout("in_ready");
                end else begin
                        @(negedge clk);                 // Transfer on the rising edge in between
                        in_valid = 1'b0;
                end
        endtask

        task automatic get_beat(input int stall, output out_beat_t beat);
                int cnt;
                int i;
                cnt = 0;
                out_ready = (stall == 0);
                while (!out_valid && cnt < wait_limit) begin
                        @(negedge clk);
                        cnt++;
                end
                if (!out_valid) begin
                        stop_on_timeout("out_valid");
                end else begin
                        for (i = 0; i < stall; i++) begin
                                compare_flag("in_ready", in_ready, 1'b0);
                                @(negedge clk);
                        end
                        compare_flag("out_valid", out_valid, 1'b1);
                        compare_flag("in_ready", in_ready, 1'b0);
                        out_ready = 1'b1;
                        beat      = out_beat;
                        @(negedge clk);
                end
        endtask

        task automatic run_sample(input sample_t s, input int stall0, input int stall1);
                sample_t   exp0;
                sample_t   exp1;
                out_beat_t beat;
                model_push(s);
                exp0 = model_output(0);
                exp1 = model_output(1);
                send_sample(s);
                get_beat(stall0, beat);
                compare_sample("out_beat.sample", beat.sample, exp0);
                compare_phase("out_beat.phase", beat.phase, 1'b0);
                get_beat(stall1, beat);
                compare_sample("out_beat.sample", beat.sample, exp1);
                compare_phase("out_beat.phase", beat.phase, 1'b1);
        endtask

        task automatic run_block(input sample_t s, input int count);
                int i;
                for (i = 0; i < count; i++) begin
                        run_sample(s, 0, 0);
                end
        endtask

        task automatic report_test(input string name, input int errs_before);
                $display("%s finished, %0d errors", name, err_count - errs_before);
        endtask

        initial begin
                int errs;
                int i;
                void'($urandom(32'h3e9a_c3eb));
                in_valid  = 1'b0;
                in_sample = '0;
                out_ready = 1'b0;
                apply_reset();

                errs = err_count;
                run_block(16'sd8000, `FIR_TAPS);        // Every tap holds data before the second reset
                apply_reset();
                compare_flag("in_ready", in_ready, 1'b1);
                compare_flag("out_valid", out_valid, 1'b0);
                run_sample(16'sd1000, 0, 0);            // Older taps must read as zeros again
                report_test("reset", errs);

                errs = err_count;
                run_block(16'sd0, `FIR_TAPS);
                run_sample(16'sd32767, 0, 0);
                run_block(16'sd0, `FIR_TAPS - 1);
                report_test("impulse", errs);

                errs = err_count;
                run_block(16'sd16384, 40);
                report_test("dc", errs);

                errs = err_count;
                run_block(16'sd32767, 32);
                run_block(sample_t'(-32768), 32);       // Step overshoot drives past both rails
                run_block(16'sd32767, 20);
                report_test("saturation", errs);

                errs = err_count;
                for (i = 0; i < 24; i++) begin
                        run_sample(sample_t'($urandom()), $urandom_range(1, 8),
                                   $urandom_range(0, 8));
                end
                report_test("backpressure", errs);

                errs = err_count;
                for (i = 0; i < 200; i++) begin
                        run_sample(sample_t'($urandom()), 0, 0);
                end
                report_test("random_stream", errs);

                $display("checks %0d, errors %0d", check_count, err_count);
                if (err_count == 0) begin
                        $display("test passed");
                end else begin
                        $display("test failed");
                end
                $finish;
        end

endmodule

//--- tb.f
+incdir+verilog
verilog/firbank_pkg.sv
verilog/rom_firbank_half.sv
verilog/sample_history.sv
verilog/polyphase_mac.sv
verilog/firbank_interp.sv
verif/firbank_properties.sv
verif/firbank_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = firbank_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
